/* source/fetch_pkg.sv */
package fetch_pkg;

    // ------------------------------------------------------------
    // widths and queue geometry
    // ------------------------------------------------------------
    localparam int INST_W     = 32;
    localparam int PC_W       = 32;
    localparam int FIFO_DEPTH = 8;
    localparam int PTR_W      = 3;   // log2 of FIFO_DEPTH

    // ------------------------------------------------------------
    // values shown to decode when nothing is buffered
    // ------------------------------------------------------------
    localparam logic [INST_W-1:0] INST_NOP = 32'h03400000;  // andi r0, r0, 0
    localparam logic [PC_W-1:0]   PC_RESET = 32'h1c000000;

    // ibar is 0x38728000 plus a 15-bit hint in the low bits
    localparam logic [16:0] IBAR_OPCODE = 17'h070e5;

    // instruction queue payload, slot 1 sits in the upper half
    typedef struct packed {
        logic [INST_W-1:0] inst1;
        logic [INST_W-1:0] inst0;
    } inst_pair_t;

    // one full fetch packet as offered by the fetch stage
    typedef struct packed {
        logic [INST_W-1:0] inst0;
        logic [INST_W-1:0] inst1;
        logic [PC_W-1:0]   pc;
    } fetch_packet_t;

endpackage

/* source/fetch_packet_if.sv */
`timescale 1ns/10ps

interface fetch_packet_if;

    logic                        valid;  // packet offered this cycle
    logic [fetch_pkg::INST_W-1:0] inst0;
    logic [fetch_pkg::INST_W-1:0] inst1;
    logic [fetch_pkg::PC_W-1:0]   pc;    // pc of inst0

    // gathers the fields into one packet value
    function automatic fetch_pkg::fetch_packet_t packet();
        fetch_pkg::fetch_packet_t p;
        p.inst0 = inst0;
        p.inst1 = inst1;
        p.pc    = pc;
        return p;
    endfunction

    modport src (
        output valid, inst0, inst1, pc
    );

    modport sink (
        input  valid, inst0, inst1, pc,
        import packet
    );

endinterface

/* source/sync_fifo.sv */
`timescale 1ns/10ps

module sync_fifo #(
    parameter type payload_t = logic [31:0]
) (
    input  logic     clk_i,
    input  logic     reset_i,
    input  logic     write_i,
    input  payload_t din_i,
    input  logic     pop_i,
    output payload_t dout_o,
    output logic     empty_o,
    output logic     full_o
);

    localparam int CNT_W = fetch_pkg::PTR_W + 1;

    payload_t                   mem [fetch_pkg::FIFO_DEPTH];
    logic [fetch_pkg::PTR_W-1:0] rd_ptr;
    logic [fetch_pkg::PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0]           count;  // one bit wider so full is distinct from empty
    logic                       do_write;
    logic                       do_pop;

    // ------------------------------------------------------------
    // strobes qualified by the current state
    // ------------------------------------------------------------
    assign do_write = write_i && !full_o;  // a write while full is lost
    assign do_pop   = pop_i && !empty_o;

    assign empty_o = (count == '0);
    assign full_o  = (count == CNT_W'(fetch_pkg::FIFO_DEPTH));

    // the head entry sits on dout_o ahead of any pop
    assign dout_o = mem[rd_ptr];

    always_ff @(posedge clk_i) begin
        if (do_write) begin
            mem[wr_ptr] <= din_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= wr_ptr + 1'b1;  // wraps at the depth
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            count <= '0;
        end else begin
            case ({do_write, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // both or neither keeps the level
            endcase
        end
    end

endmodule

/* source/pre_decoder.sv */
`timescale 1ns/10ps

module pre_decoder (
    input  logic                         clk_i,
    input  logic                         reset_i,
    fetch_packet_if.sink                 pkt,
    input  logic                         accept_i,
    output logic                         ibar_o,
    output logic                         ibar_pos_o,
    output logic [fetch_pkg::PC_W-1:0]    ibar_pc_o
);

    localparam int OP_LSB = fetch_pkg::INST_W - 17;

    logic                       hit0;
    logic                       hit1;
    logic                       hit_any;
    logic [fetch_pkg::PC_W-1:0] restart_pc;

    // ------------------------------------------------------------
    // opcode match on both slots
    // ------------------------------------------------------------
    // the hint field in the low 15 bits does not take part
    assign hit0 = (pkt.inst0[fetch_pkg::INST_W-1:OP_LSB] == fetch_pkg::IBAR_OPCODE);
    assign hit1 = (pkt.inst1[fetch_pkg::INST_W-1:OP_LSB] == fetch_pkg::IBAR_OPCODE);

    assign hit_any = pkt.valid && accept_i && (hit0 || hit1);

    // fetch restarts right after the barrier, slot 0 wins if both match
    always_comb begin
        if (hit0) begin
            restart_pc = pkt.pc + fetch_pkg::PC_W'(4);
        end else begin
            restart_pc = pkt.pc + fetch_pkg::PC_W'(8);
        end
    end

    // ------------------------------------------------------------
    // registered report, one cycle after acceptance
    // ------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            ibar_o <= 1'b0;
        end else begin
            ibar_o <= hit_any;  // single-cycle pulse
        end
    end

    // position and pc only mean something while ibar_o is high
    always_ff @(posedge clk_i) begin
        if (hit_any) begin
            ibar_pos_o <= !hit0;
            ibar_pc_o  <= restart_pc;
        end
    end

endmodule

/* source/fetch_buffer.sv */
`timescale 1ns/10ps

module fetch_buffer (
    input  logic                          clk_i,
    input  logic                          reset_i,
    fetch_packet_if.sink                  pkt,
    input  logic                          pop_i,
    output logic                          accept_o,
    output logic [fetch_pkg::INST_W-1:0]   inst0_o,
    output logic [fetch_pkg::INST_W-1:0]   inst1_o,
    output logic [fetch_pkg::PC_W-1:0]     pc_o,
    output logic                          empty_o,
    output logic                          full_o
);

    fetch_pkg::fetch_packet_t   in_pkt;
    fetch_pkg::inst_pair_t      inst_din;
    fetch_pkg::inst_pair_t      inst_dout;
    logic [fetch_pkg::PC_W-1:0] pc_dout;
    logic                       empty;
    logic                       full;
    logic                       bypass;
    logic                       write_en;
    logic                       pop_en;

    assign in_pkt = pkt.packet();

    // ------------------------------------------------------------
    // write, bypass and pop strobes
    // ------------------------------------------------------------
    assign bypass   = empty && pkt.valid && pop_i;  // packet goes straight to decode
    assign write_en = pkt.valid && !full && !bypass;
    assign pop_en   = pop_i && !empty;
    assign accept_o = write_en || bypass;

    assign inst_din.inst0 = in_pkt.inst0;
    assign inst_din.inst1 = in_pkt.inst1;

    assign empty_o = empty;
    assign full_o  = full;

    // the bypass packet comes first, then the queue head, else a NOP pair
    always_comb begin
        if (bypass) begin
            inst0_o = in_pkt.inst0;
            inst1_o = in_pkt.inst1;
            pc_o    = in_pkt.pc;
        end else if (!empty) begin
            inst0_o = inst_dout.inst0;
            inst1_o = inst_dout.inst1;
            pc_o    = pc_dout;
        end else begin
            inst0_o = fetch_pkg::INST_NOP;
            inst1_o = fetch_pkg::INST_NOP;
            pc_o    = fetch_pkg::PC_RESET;
        end
    end

    // ------------------------------------------------------------
    // instruction pair queue and its pc companion
    // ------------------------------------------------------------
    sync_fifo #(
        .payload_t (fetch_pkg::inst_pair_t)
    ) inst_buf (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .write_i (write_en),
        .din_i   (inst_din),
        .pop_i   (pop_en),
        .dout_o  (inst_dout),
        .empty_o (empty),
        .full_o  (full)
    );

    // both queues move together, so the flags of this one stay open
    sync_fifo #(
        .payload_t (logic [fetch_pkg::PC_W-1:0])
    ) pc_buf (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .write_i (write_en),
        .din_i   (in_pkt.pc),
        .pop_i   (pop_en),
        .dout_o  (pc_dout),
        .empty_o (),
        .full_o  ()
    );

endmodule

/* source/fetch_frontend_top.sv */
`timescale 1ns/10ps

module fetch_frontend_top (
    input  logic                          clk_i,
    input  logic                          reset_i,

    // fetch side
    input  logic                          valid_i,
    input  logic [fetch_pkg::INST_W-1:0]   inst0_i,
    input  logic [fetch_pkg::INST_W-1:0]   inst1_i,
    input  logic [fetch_pkg::PC_W-1:0]     pc_i,

    // decode side
    input  logic                          pop_i,
    output logic [fetch_pkg::INST_W-1:0]   inst0_o,
    output logic [fetch_pkg::INST_W-1:0]   inst1_o,
    output logic [fetch_pkg::PC_W-1:0]     pc_o,
    output logic                          empty_o,
    output logic                          full_o,

    // barrier report back to fetch
    output logic                          ibar_o,
    output logic                          ibar_pos_o,
    output logic [fetch_pkg::PC_W-1:0]     ibar_pc_o
);

    logic accept;  // packet was stored or bypassed

    fetch_packet_if pkt_if ();

    // ------------------------------------------------------------
    // packet interface filled from the fetch ports
    // ------------------------------------------------------------
    assign pkt_if.valid = valid_i;
    assign pkt_if.inst0 = inst0_i;
    assign pkt_if.inst1 = inst1_i;
    assign pkt_if.pc    = pc_i;

    fetch_buffer u_fetch_buffer (
        .clk_i    (clk_i),
        .reset_i  (reset_i),
        .pkt      (pkt_if.sink),
        .pop_i    (pop_i),
        .accept_o (accept),
        .inst0_o  (inst0_o),
        .inst1_o  (inst1_o),
        .pc_o     (pc_o),
        .empty_o  (empty_o),
        .full_o   (full_o)
    );

    // sees every offered packet but only reports accepted ones
    pre_decoder u_pre_decoder (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .pkt        (pkt_if.sink),
        .accept_i   (accept),
        .ibar_o     (ibar_o),
        .ibar_pos_o (ibar_pos_o),
        .ibar_pc_o  (ibar_pc_o)
    );

endmodule

/* tb/tb_clock_gen.sv */
`timescale 1ns/10ps

module tb_clock_gen (
    output logic clk_o,
    output logic reset_o
);

    localparam int RESET_CYCLES = 8;

    // 100 ns period
    initial begin
        clk_o = 1'b0;
        forever begin
            #50 clk_o = ~clk_o;
        end
    end

    // released with the same 10 ns offset as the other inputs
    initial begin
        reset_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #10;
        reset_o = 1'b0;
    end

endmodule

/* tb/tb_fetch_frontend.sv */
`timescale 1ns/10ps

module tb_fetch_frontend;

    localparam int DEPTH      = fetch_pkg::FIFO_DEPTH;
    localparam int WAIT_LIMIT = 40;  // cycles before any wait gives up

    logic                         clk;
    logic                         rst;
    logic                         valid_d;
    logic [fetch_pkg::INST_W-1:0] inst0_d;
    logic [fetch_pkg::INST_W-1:0] inst1_d;
    logic [fetch_pkg::PC_W-1:0]   pc_d;
    logic                         pop_d;
    logic [fetch_pkg::INST_W-1:0] out_inst0;
    logic [fetch_pkg::INST_W-1:0] out_inst1;
    logic [fetch_pkg::PC_W-1:0]   out_pc;
    logic                         empty_o;
    logic                         full_o;
    logic                         ibar;
    logic                         ibar_pos;
    logic [fetch_pkg::PC_W-1:0]   ibar_pc;

    fetch_pkg::fetch_packet_t   model_q [$];  // packets the buffer should hold, head first
    logic                       exp_ibar;
    logic                       exp_pos;
    logic [fetch_pkg::PC_W-1:0] exp_pc;
    integer                     seed;
    int                         checks;
    int                         errors;
    int                         test_errors;
    string                      test_name;

    tb_clock_gen clock_gen (
        .clk_o   (clk),
        .reset_o (rst)
    );

    fetch_frontend_top UUT (
        .clk_i      (clk),
        .reset_i    (rst),
        .valid_i    (valid_d),
        .inst0_i    (inst0_d),
        .inst1_i    (inst1_d),
        .pc_i       (pc_d),
        .pop_i      (pop_d),
        .inst0_o    (out_inst0),
        .inst1_o    (out_inst1),
        .pc_o       (out_pc),
        .empty_o    (empty_o),
        .full_o     (full_o),
        .ibar_o     (ibar),
        .ibar_pos_o (ibar_pos),
        .ibar_pc_o  (ibar_pc)
    );

    // ------------------------------------------------------------
    // compare tasks
    // ------------------------------------------------------------
    task automatic check_packet(input string what, input fetch_pkg::fetch_packet_t exp,
                                input fetch_pkg::fetch_packet_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("CHECK FAILED %s %s: expected %h, actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic check_flag(input string what, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("CHECK FAILED %s %s: expected %b, actual %b", test_name, what, exp, act);
        end
    endtask

    task automatic check_pc(input string what, input logic [fetch_pkg::PC_W-1:0] exp,
                            input logic [fetch_pkg::PC_W-1:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("CHECK FAILED %s %s: expected %h, actual %h", test_name, what, exp, act);
        end
    endtask

    // ------------------------------------------------------------
    // stimulus and model
    // ------------------------------------------------------------
    function automatic logic is_ibar(input logic [fetch_pkg::INST_W-1:0] inst);
        return inst[fetch_pkg::INST_W-1 -: 17] == fetch_pkg::IBAR_OPCODE;
    endfunction

    // bit 0 of slots puts an ibar in slot 0, bit 1 in slot 1
    task automatic random_packet(input int slots, output fetch_pkg::fetch_packet_t p);
        logic [14:0] hint;
        p.inst0 = $random(seed);
        p.inst1 = $random(seed);
        p.pc    = $random(seed);
        p.pc[2:0] = 3'b000;
        hint = $random(seed);
        if (slots[0]) begin
            p.inst0 = {fetch_pkg::IBAR_OPCODE, hint};
        end
        if (slots[1]) begin
            hint = $random(seed);
            p.inst1 = {fetch_pkg::IBAR_OPCODE, hint};
        end
    endtask

    // one clock cycle, entered and left 10 ns after a rising edge
    task automatic step(input logic v, input fetch_pkg::fetch_packet_t p, input logic take);
        fetch_pkg::fetch_packet_t   exp_pkt;
        fetch_pkg::fetch_packet_t   act_pkt;
        logic                       m_empty;
        logic                       m_full;
        logic                       pass_through;
        logic                       accepted;
        logic                       next_ibar;
        logic                       next_pos;
        logic [fetch_pkg::PC_W-1:0] next_pc;
        valid_d = v;
        inst0_d = p.inst0;
        inst1_d = p.inst1;
        pc_d    = p.pc;
        pop_d   = take;
        #80;  // outputs have settled, next edge is 10 ns away
        m_empty      = (model_q.size() == 0);
        m_full       = (model_q.size() == DEPTH);
        pass_through = m_empty && v && take;
        if (pass_through) begin
            exp_pkt = p;
        end else if (!m_empty) begin
            exp_pkt = model_q[0];
        end else begin
            exp_pkt.inst0 = fetch_pkg::INST_NOP;
            exp_pkt.inst1 = fetch_pkg::INST_NOP;
            exp_pkt.pc    = fetch_pkg::PC_RESET;
        end
        act_pkt.inst0 = out_inst0;
        act_pkt.inst1 = out_inst1;
        act_pkt.pc    = out_pc;
        check_packet("packet", exp_pkt, act_pkt);
        check_flag("empty", m_empty, empty_o);
        check_flag("full", m_full, full_o);
        check_flag("ibar", exp_ibar, ibar);
        if (exp_ibar) begin
            check_flag("ibar_pos", exp_pos, ibar_pos);
            check_pc("ibar_pc", exp_pc, ibar_pc);
        end
        accepted  = pass_through || (v && !m_full);
        next_ibar = accepted && (is_ibar(p.inst0) || is_ibar(p.inst1));
        next_pos  = !is_ibar(p.inst0);  // slot 0 wins when both match
        next_pc   = p.pc + (is_ibar(p.inst0) ? 32'd4 : 32'd8);
        if (take && !m_empty) begin
            void'(model_q.pop_front());
        end
        if (v && !m_full && !pass_through) begin
            model_q.push_back(p);
        end
        @(posedge clk);
        exp_ibar = next_ibar;
        if (next_ibar) begin
            exp_pos = next_pos;
            exp_pc  = next_pc;
        end
        #10;
    endtask

    task automatic fill(output int stores);
        fetch_pkg::fetch_packet_t p;
        stores = 0;
        while (!full_o && stores < WAIT_LIMIT) begin
            random_packet(0, p);
            step(1'b1, p, 1'b0);
            stores++;
        end
        if (!full_o) begin
            errors++;
            $display("%s: full flag never rose within %0d cycles", test_name, WAIT_LIMIT);
        end
    endtask

    task automatic drain();
        fetch_pkg::fetch_packet_t p;
        int n;
        n = 0;
        while (!empty_o && n < WAIT_LIMIT) begin
            random_packet(0, p);
            step(1'b0, p, 1'b1);
            n++;
        end
        if (!empty_o) begin
            errors++;
            $display("%s: buffer did not drain within %0d cycles", test_name, WAIT_LIMIT);
        end
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = errors;
    endtask

    task automatic end_test();
        if (errors == test_errors) begin
            $display("test %s: passed", test_name);
        end else begin
            $display("test %s: %0d errors", test_name, errors - test_errors);
        end
    endtask

    // ------------------------------------------------------------
    // test sequence
    // ------------------------------------------------------------
    initial begin
        fetch_pkg::fetch_packet_t p;
        int   n;
        int   stores;
        int   slots;
        logic v;
        logic take;
        seed      = 63629;
        checks    = 0;
        errors    = 0;
        valid_d   = 1'b0;
        inst0_d   = '0;
        inst1_d   = '0;
        pc_d      = '0;
        pop_d     = 1'b0;
        exp_ibar  = 1'b0;
        exp_pos   = 1'b0;
        exp_pc    = '0;
        test_name = "reset";

        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (rst !== 1'b0 && n < WAIT_LIMIT);
        if (rst !== 1'b0) begin
            errors++;
            $display("reset was never released within %0d cycles", WAIT_LIMIT);
        end
        #10;

        start_test("reset");
        random_packet(3, p);
        step(1'b0, p, 1'b0);  // an ibar on an idle bus must not report
        step(1'b0, p, 1'b1);  // pop on empty is ignored
        end_test();

        start_test("fill_and_drain");
        fill(stores);
        checks++;
        if (stores != DEPTH) begin
            errors++;
            $display("CHECK FAILED %s stores to full: expected %0d, actual %0d",
                     test_name, DEPTH, stores);
        end
        random_packet(3, p);
        step(1'b1, p, 1'b0);  // dropped while full
        drain();
        end_test();

        start_test("bypass");
        random_packet(0, p);
        step(1'b1, p, 1'b1);
        random_packet(1, p);
        step(1'b0, p, 1'b0);
        step(1'b1, p, 1'b1);  // bypassed ibar still reports
        random_packet(0, p);
        step(1'b0, p, 1'b0);
        end_test();

        start_test("random");
        for (int i = 0; i < 300; i++) begin
            slots = (($random(seed) & 7) == 0) ? ($random(seed) & 3) : 0;
            random_packet(slots, p);
            v    = !full_o && (($random(seed) & 3) != 0);  // producer obeys full
            take = ($random(seed) & 1) != 0;
            step(v, p, take);
        end
        drain();
        end_test();

        start_test("barrier");
        for (int k = 1; k <= 3; k++) begin
            random_packet(k, p);
            step(1'b1, p, 1'b0);
            random_packet(0, p);
            step(1'b0, p, 1'b0);
        end
        drain();
        fill(stores);
        random_packet(3, p);
        step(1'b1, p, 1'b0);
        random_packet(0, p);
        step(1'b0, p, 1'b0);  // the dropped packet gives no report
        drain();
        end_test();

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

/* filelist.f */
source/fetch_pkg.sv
source/fetch_packet_if.sv
source/sync_fifo.sv
source/pre_decoder.sv
source/fetch_buffer.sv
source/fetch_frontend_top.sv
tb/tb_clock_gen.sv
tb/tb_fetch_frontend.sv
